//--- hw/obj_pkg.sv
package obj_pkg;

    localparam int OBJ_LANES = 4;                // number of lane units working on one line.
    localparam int TABLE_AW  = 10;               // address width of one table half.
    localparam int OBJ_WORDS = 4;                // each object spans x, y, code and attr.
    localparam int WORD_W    = 16;               // width of a VRAM word and a table word.
    localparam int POS_W     = 9;                // screen coordinates wrap at 512.
    localparam int OBJ_SIZE  = 16;               // objects are square tiles of this size.
    localparam int PAL_W     = 5;                // palette field sits in attr bits 4..0.
    localparam int PXL_W     = 9;                // output pixel is palette then code nibble.
    localparam int VRAM_AW   = 23;               // VRAM is word addressed from bit 1 up.

    // derived widths for the scanner and the lanes.
    localparam int NIB_W  = PXL_W - PAL_W;       // code bits that reach the pixel.
    localparam int WSEL_W = $clog2(OBJ_WORDS);   // selects a word inside an object.
    localparam int ENT_W  = TABLE_AW - WSEL_W;   // indexes an entry in one table half.
    localparam int OBJ_MAX = 2 ** ENT_W;         // entries per half, 256 here.
    localparam int LANE_W = $clog2(OBJ_LANES + 1); // the fill count must reach OBJ_LANES.

    // word positions inside one object entry.
    localparam logic [WSEL_W-1:0] W_X    = 2'd0;
    localparam logic [WSEL_W-1:0] W_Y    = 2'd1;
    localparam logic [WSEL_W-1:0] W_CODE = 2'd2;
    localparam logic [WSEL_W-1:0] W_ATTR = 2'd3;

    // the burst stops once this word offset has been taken.
    localparam logic [TABLE_AW-1:0] FETCH_LAST = 10'h3fe;

    // an attr word with this value ends the table walk.
    localparam logic [WORD_W-1:0] OBJ_END_ATTR = 16'hff00;

endpackage

//--- hw/obj_table.sv
`timescale 1ns/1ps

module obj_table import obj_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                vb,
    input  logic [WORD_W-1:0]   vram_base,
    input  logic [WORD_W-1:0]   vram_data,
    input  logic                vram_ok,
    input  logic [TABLE_AW-1:0] table_addr,
    output logic [VRAM_AW:1]    vram_addr,
    output logic                vram_cs,
    output logic [WORD_W-1:0]   table_data
);

    typedef enum logic {ST_IDLE, ST_FETCH} state_t;

    state_t              st;                     // fetch machine state.
    logic                frame;                  // selects the half being displayed.
    logic                last_vb;                // vb from the previous cycle.
    logic                wait_cycle;             // blocks a word right after an address step.
    logic                wr_en;                  // write strobe for the idle half.
    logic [TABLE_AW-1:0] wr_addr;                // offset of the word being written.
    logic [WORD_W-1:0]   wr_data;                // word captured from VRAM.
    logic                take;                   // a VRAM word is accepted this cycle.

    // both halves start out as zero so that reads before the first fetch are defined.
    logic [WORD_W-1:0]   ram [0:2**(TABLE_AW+1)-1] = '{default: '0};

    assign take = (st == ST_FETCH) && vram_ok && !wait_cycle; // wait cycle gives VRAM time.

    always_ff @(posedge clk) begin
        if (wr_en) begin
            ram[{~frame, wr_addr}] <= wr_data;   // the fetch fills the half not on screen.
        end
        table_data <= ram[{frame, table_addr}];  // scanner reads return one cycle later.
    end

    always_ff @(posedge clk) begin
        if (take) begin
            wr_data <= vram_data;                // data is latched when the address steps.
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st         <= ST_IDLE;
            frame      <= 1'b0;
            last_vb    <= 1'b0;
            wait_cycle <= 1'b1;
            wr_en      <= 1'b0;
            wr_addr    <= '1;
            vram_cs    <= 1'b0;
            vram_addr  <= '0;
        end else begin
            last_vb <= vb;
            wr_en   <= take;                     // each accepted word is written once.
            case (st)
                ST_IDLE: begin
                    vram_addr  <= {vram_base[WORD_W-1:3], {TABLE_AW{1'b0}}}; // table is 1k aligned.
                    wr_addr    <= '1;            // first accepted word wraps this to zero.
                    wait_cycle <= 1'b1;
                    vram_cs    <= 1'b0;
                    if (!vb && last_vb) begin    // vertical blank has just ended.
                        vram_cs <= 1'b1;         // held high for the whole burst.
                        frame   <= ~frame;       // last frame's fetch goes on screen.
                        st      <= ST_FETCH;
                    end
                end
                ST_FETCH: begin
                    wait_cycle <= 1'b0;
                    if (take) begin
                        vram_addr  <= vram_addr + VRAM_AW'(1);
                        wr_addr    <= wr_addr + 1'b1;
                        wait_cycle <= 1'b1;
                        if (vram_addr[TABLE_AW:1] == FETCH_LAST) begin // 1023 words in total.
                            vram_cs <= 1'b0;
                            st      <= ST_IDLE;
                        end
                    end
                end
                default: st <= ST_IDLE;
            endcase
        end
    end

    // a vb fall must find the burst finished, or the halves would not swap.
    assert property (@(posedge clk) disable iff (rst)
        $fell(vb) |-> (st == ST_IDLE));

endmodule

//--- hw/obj_scan.sv
`timescale 1ns/1ps

module obj_scan import obj_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 hb,
    input  logic [POS_W-1:0]     vpos,
    input  logic [WORD_W-1:0]    table_data,
    output logic [TABLE_AW-1:0]  table_addr,
    output logic                 lane_clr,
    output logic [OBJ_LANES-1:0] lane_load,
    output logic [POS_W-1:0]     obj_x,
    output logic [PAL_W-1:0]     obj_pal,
    output logic [NIB_W-1:0]     obj_nib
);

    logic                scan;                   // high while the table walk runs.
    logic                hb_d;                   // hb from the previous cycle.
    logic                dvalid;                 // table_data answers a scan read.
    logic [TABLE_AW-1:0] addr_d;                 // address that table_data belongs to.
    logic [LANE_W-1:0]   fill;                   // next free lane.
    logic [LANE_W-1:0]   fill_nxt;
    logic [POS_W-1:0]    x_r;                    // x of the object being read.
    logic [POS_W-1:0]    y_r;                    // y of the object being read.
    logic [NIB_W-1:0]    nib_r;                  // low code bits of the object being read.
    logic [WSEL_W-1:0]   wsel;
    logic [POS_W-1:0]    dy;
    logic                at_attr;
    logic                is_end;
    logic                visible;
    logic                last_ent;
    logic                load_now;

    assign wsel     = addr_d[WSEL_W-1:0];        // word index of the returning data.
    assign at_attr  = scan && dvalid && (wsel == W_ATTR);
    assign is_end   = (table_data == OBJ_END_ATTR);
    assign dy       = vpos - y_r;                // wraps modulo 512 like the screen.
    assign visible  = (dy < POS_W'(OBJ_SIZE));   // line falls inside the object rows.
    assign last_ent = (addr_d[TABLE_AW-1:WSEL_W] == ENT_W'(OBJ_MAX - 1));
    assign load_now = at_attr && !is_end && visible;
    assign fill_nxt = fill + 1'b1;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            scan       <= 1'b0;
            hb_d       <= 1'b0;
            dvalid     <= 1'b0;
            addr_d     <= '0;
            table_addr <= '0;
            fill       <= '0;
            lane_clr   <= 1'b0;
            lane_load  <= '0;
        end else begin
            hb_d      <= hb;
            lane_clr  <= 1'b0;                   // both strobes last a single cycle.
            lane_load <= '0;
            if (!scan) begin
                dvalid <= 1'b0;
                if (hb && !hb_d) begin           // horizontal blank has just begun.
                    scan       <= 1'b1;
                    lane_clr   <= 1'b1;          // lanes drop last line's objects.
                    table_addr <= '0;
                    fill       <= '0;
                end
            end else if (!hb) begin
                scan <= 1'b0;                    // lanes must stay fixed during the line.
            end else begin
                dvalid     <= 1'b1;
                addr_d     <= table_addr;        // tracks the read in flight.
                table_addr <= table_addr + 1'b1; // next read goes out while data returns.
                if (at_attr) begin
                    if (load_now) begin
                        lane_load <= OBJ_LANES'(1) << fill;
                        fill      <= fill_nxt;
                    end
                    if (is_end || last_ent || (load_now && fill_nxt == LANE_W'(OBJ_LANES))) begin
                        scan <= 1'b0;            // marker, end of table or all lanes busy.
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dvalid) begin
            case (wsel)
                W_X:     x_r   <= table_data[POS_W-1:0];
                W_Y:     y_r   <= table_data[POS_W-1:0];
                W_CODE:  nib_r <= table_data[NIB_W-1:0];
                default: ;                       // attr is used as it arrives.
            endcase
        end
        if (load_now) begin
            obj_x   <= x_r;                      // valid together with lane_load.
            obj_pal <= table_data[PAL_W-1:0];
            obj_nib <= nib_r;
        end
    end

    // a lane is only loaded while the line is still blanked.
    assert property (@(posedge clk) disable iff (rst) (|lane_load) |-> hb);

endmodule

//--- hw/obj_lane.sv
`timescale 1ns/1ps

module obj_lane import obj_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             clr,
    input  logic             load,
    input  logic [POS_W-1:0] obj_x,
    input  logic [PAL_W-1:0] obj_pal,
    input  logic [NIB_W-1:0] obj_nib,
    input  logic [POS_W-1:0] hpos,
    input  logic             hb,
    output logic             hit,
    output logic [PXL_W-1:0] color
);

    logic             full;                      // the lane holds an object.
    logic [POS_W-1:0] x_r;                       // left edge of the held object.
    logic [PXL_W-1:0] col_r;                     // colour of the held object.
    logic [POS_W-1:0] dx;
    logic             in_span;

    assign dx      = hpos - x_r;                 // wraps modulo 512 like the screen.
    assign in_span = (dx < POS_W'(OBJ_SIZE));    // covers x up to x+15.

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            full <= 1'b0;
            hit  <= 1'b0;
        end else begin
            if (clr) begin
                full <= 1'b0;                    // emptied at the start of each blank.
            end else if (load) begin
                full <= 1'b1;
            end
            hit <= full && !hb && in_span;       // no hits while the beam is blanked.
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            x_r   <= obj_x;
            col_r <= {obj_pal, obj_nib};         // palette above the code nibble.
        end
        color <= col_r;                          // lines up with hit.
    end

    // the scanner never clears and loads a lane in one cycle.
    assert property (@(posedge clk) disable iff (rst) !(load && clr));

endmodule

//--- hw/obj_merge.sv
`timescale 1ns/1ps

module obj_merge import obj_pkg::*; (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       vb,
    input  logic [OBJ_LANES-1:0]       hit,
    input  logic [OBJ_LANES*PXL_W-1:0] color,
    output logic [PXL_W-1:0]           pxl,
    output logic                       pxl_valid
);

    logic             vb_d;                      // vb aligned with the lane outputs.
    logic             any_hit;                   // at least one lane covers this pixel.
    logic [PXL_W-1:0] pick;                      // colour of the winning lane.

    // lower lanes hold earlier table entries and win the pixel.
    always_comb begin
        any_hit = 1'b0;
        pick    = '0;
        for (int i = OBJ_LANES - 1; i >= 0; i--) begin
            if (hit[i]) begin
                any_hit = 1'b1;
                pick    = color[i*PXL_W +: PXL_W]; // a lower index overrides later.
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vb_d      <= 1'b1;
            pxl_valid <= 1'b0;
            pxl       <= '0;
        end else begin
            vb_d      <= vb;                     // matches the lane register stage.
            pxl_valid <= any_hit && !vb_d;
            pxl       <= (any_hit && !vb_d) ? pick : '0; // idle pixels read as zero.
        end
    end

endmodule

//--- hw/obj_top.sv
`timescale 1ns/1ps

module obj_top import obj_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              vb,
    input  logic              hb,
    input  logic [POS_W-1:0]  vpos,
    input  logic [POS_W-1:0]  hpos,
    input  logic [WORD_W-1:0] vram_base,
    input  logic [WORD_W-1:0] vram_data,
    input  logic              vram_ok,
    output logic [VRAM_AW:1]  vram_addr,
    output logic              vram_cs,
    output logic [PXL_W-1:0]  pxl,
    output logic              pxl_valid
);

    logic [TABLE_AW-1:0]        table_addr;      // scanner read address.
    logic [WORD_W-1:0]          table_data;      // registered table word.
    logic                       lane_clr;        // empties every lane.
    logic [OBJ_LANES-1:0]       lane_load;       // one-hot lane select.
    logic [POS_W-1:0]           obj_x;
    logic [PAL_W-1:0]           obj_pal;
    logic [NIB_W-1:0]           obj_nib;
    logic [OBJ_LANES-1:0]       hit;             // per-lane coverage of hpos.
    logic [OBJ_LANES*PXL_W-1:0] color;           // per-lane colours side by side.

    obj_table u_table (
        .clk        (clk),
        .rst        (rst),
        .vb         (vb),
        .vram_base  (vram_base),
        .vram_data  (vram_data),
        .vram_ok    (vram_ok),
        .table_addr (table_addr),
        .vram_addr  (vram_addr),
        .vram_cs    (vram_cs),
        .table_data (table_data)
    );

    obj_scan u_scan (
        .clk        (clk),
        .rst        (rst),
        .hb         (hb),
        .vpos       (vpos),
        .table_data (table_data),
        .table_addr (table_addr),
        .lane_clr   (lane_clr),
        .lane_load  (lane_load),
        .obj_x      (obj_x),
        .obj_pal    (obj_pal),
        .obj_nib    (obj_nib)
    );

    // every lane sees the same object bus and picks it up on its own load bit.
    for (genvar i = 0; i < OBJ_LANES; i++) begin : g_lane
        obj_lane u_lane (
            .clk     (clk),
            .rst     (rst),
            .clr     (lane_clr),
            .load    (lane_load[i]),
            .obj_x   (obj_x),
            .obj_pal (obj_pal),
            .obj_nib (obj_nib),
            .hpos    (hpos),
            .hb      (hb),
            .hit     (hit[i]),
            .color   (color[i*PXL_W +: PXL_W])
        );
    end

    obj_merge u_merge (
        .clk       (clk),
        .rst       (rst),
        .vb        (vb),
        .hit       (hit),
        .color     (color),
        .pxl       (pxl),
        .pxl_valid (pxl_valid)
    );

endmodule

//--- sim/obj_vram_model.sv
`timescale 1ns/1ps

module obj_vram_model import obj_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               img_sel,          // picks which stored table the burst reads.
    input  logic               vram_cs,
    input  logic [VRAM_AW:1]   vram_addr,
    output logic [WORD_W-1:0]  vram_data,
    output logic               vram_ok
);

    logic [WORD_W-1:0] img [0:1][0:2**TABLE_AW-1]; // two table images, word offsets only.
    integer            seed = 32'h35fb0e22;      // fixed seed keeps the stalls repeatable.
    logic              armed;                    // a request is being served.
    logic [VRAM_AW:1]  last_addr;                // address of the request in service.
    logic [2:0]        cnt;                      // cycles left before the word is ready.

    // fills one word of one image before the run starts.
    task automatic load_word(input int sel, input int idx, input logic [WORD_W-1:0] w);
        img[sel][idx] = w;
    endtask

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            vram_ok   <= 1'b0;
            vram_data <= '0;
            armed     <= 1'b0;
            last_addr <= '0;
            cnt       <= '0;
        end else if (!vram_cs) begin
            vram_ok <= 1'b0;                     // no burst, nothing to answer.
            armed   <= 1'b0;
        end else if (!armed || vram_addr != last_addr) begin
            vram_ok   <= 1'b0;                   // a new address withdraws the old word.
            armed     <= 1'b1;
            last_addr <= vram_addr;
            cnt       <= 3'(1 + ($random(seed) & 3)); // latency of 1 to 4 cycles.
        end else if (cnt != 0) begin
            cnt <= cnt - 1'b1;
            if (cnt == 1) begin
                vram_ok   <= 1'b1;               // word and strobe appear together.
                vram_data <= img[img_sel][vram_addr[TABLE_AW:1]];
            end
        end
    end

endmodule

//--- sim/obj_tb.sv
`timescale 1ns/1ps

module obj_tb import obj_pkg::*; ();

    localparam int FRAMES      = 3;
    localparam int LINES       = 7;
    localparam int VB_LEN      = 256;            // also gives a slow fetch time to finish.
    localparam int HB_LEN      = 4 * (OBJ_MAX + 1) + 4 + 16; // longest scan plus margin.
    localparam int LINE_LEN    = HB_LEN + 512;
    localparam int FETCH_WORDS = 1023;           // words copied per burst.
    localparam int FETCH_WORST = FETCH_WORDS * 8;
    localparam int LIMIT = FRAMES * (FETCH_WORST + VB_LEN + LINES * LINE_LEN) * 2;
    localparam int MAX_ROWS    = 32;

    typedef struct packed {
        logic [1:0]       frame;                 // frame number of the check.
        logic [1:0]       img;                   // image on screen, 0 is the empty table.
        logic [POS_W-1:0] vpos;
        logic [POS_W-1:0] hpos;
        logic             v;                     // expected pxl_valid.
        logic [PXL_W-1:0] p;                     // expected pxl.
    } row_t;

    logic              clk = 1'b0;
    logic              rst;
    logic              vb;
    logic              hb;
    logic [POS_W-1:0]  vpos;
    logic [POS_W-1:0]  hpos;
    logic [WORD_W-1:0] vram_base;
    logic [WORD_W-1:0] vram_data;
    logic              vram_ok;
    logic [VRAM_AW:1]  vram_addr;
    logic              vram_cs;
    logic [PXL_W-1:0]  pxl;
    logic              pxl_valid;
    logic              img_sel;

    logic [WORD_W-1:0] img [1:2][0:2**TABLE_AW-1]; // own copies of images A and B.
    row_t              rows [MAX_ROWS];
    logic              row_seen [MAX_ROWS];      // the row was compared at least once.
    int                n_rows = 0;
    int                mism = 0;                 // wrong output values.
    int                other = 0;                // every other kind of failure.
    int                cycles = 0;
    int                cur_frame = 0;
    int                disp_id = 0;
    logic [POS_W-1:0]  ref_x [OBJ_LANES];        // objects the rules put on this line.
    logic [PXL_W-1:0]  ref_c [OBJ_LANES];
    int                ref_n;
    logic              p_chk [3] = '{1'b0, 1'b0, 1'b0}; // expectation pipe, 2 cycles deep.
    logic              p_v [3];
    logic [PXL_W-1:0]  p_c [3];
    logic              p_act [3];
    int                p_fr [3];
    logic [POS_W-1:0]  p_vp [3];
    logic [POS_W-1:0]  p_hp [3];
    logic              cs_was = 1'b0;            // vram_cs at the previous sample.
    logic [VRAM_AW:1]  va_was = '0;              // vram_addr at the previous sample.
    int                steps = 0;                // address steps in the current burst.
    int                bursts = 0;               // bursts that have ended.

    obj_top UUT (.clk(clk), .rst(rst), .vb(vb), .hb(hb), .vpos(vpos), .hpos(hpos),
        .vram_base(vram_base), .vram_data(vram_data), .vram_ok(vram_ok),
        .vram_addr(vram_addr), .vram_cs(vram_cs), .pxl(pxl), .pxl_valid(pxl_valid));

    obj_vram_model vram (.clk(clk), .rst(rst), .img_sel(img_sel), .vram_cs(vram_cs),
        .vram_addr(vram_addr), .vram_data(vram_data), .vram_ok(vram_ok));

    always #5 clk = ~clk;                        // 10 ns period.

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == LIMIT) begin
            $display("run timed out after %0d cycles without finishing", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    // word as the display half holds it; offset 3ff is never fetched and stays zero.
    function automatic logic [WORD_W-1:0] img_word(input int id, input int i);
        return (id == 0 || i == 1023) ? '0 : img[id][i];
    endfunction

    function automatic logic [POS_W-1:0] line_at(input int k);
        case (k)
            0: return 9'd39;
            1: return 9'd40;
            2: return 9'd55;
            3: return 9'd56;
            4: return 9'd200;
            5: return 9'd3;
            default: return 9'd4;
        endcase
    endfunction

    task automatic set_obj(input int id, input int e, input int x, input int y,
                           input logic [WORD_W-1:0] code, input logic [WORD_W-1:0] attr);
        img[id][4*e]     = WORD_W'(x);
        img[id][4*e + 1] = WORD_W'(y);
        img[id][4*e + 2] = code;
        img[id][4*e + 3] = attr;
    endtask

    task automatic add_row(input int f, input int id, input int vp, input int hp,
                           input logic v, input logic [PXL_W-1:0] p);
        rows[n_rows] = {2'(f), 2'(id), POS_W'(vp), POS_W'(hp), v, p};
        row_seen[n_rows] = 1'b0;
        n_rows++;
    endtask

    // walks the table in order and keeps the first four objects that cross the line.
    task automatic build_lanes(input int id, input logic [POS_W-1:0] line);
        logic [WORD_W-1:0] a;
        logic [WORD_W-1:0] x;
        logic [WORD_W-1:0] y;
        logic [WORD_W-1:0] code;
        logic [POS_W-1:0]  dy;
        ref_n = 0;
        for (int e = 0; e < OBJ_MAX && ref_n < OBJ_LANES; e++) begin
            a    = img_word(id, 4*e + 3);
            x    = img_word(id, 4*e);
            y    = img_word(id, 4*e + 1);
            code = img_word(id, 4*e + 2);
            if (a == OBJ_END_ATTR) break;        // nothing past the marker is drawn.
            dy = line - y[POS_W-1:0];            // modulo 512 by the width.
            if (dy < POS_W'(OBJ_SIZE)) begin
                ref_x[ref_n] = x[POS_W-1:0];
                ref_c[ref_n] = {a[PAL_W-1:0], code[NIB_W-1:0]};
                ref_n++;
            end
        end
    endtask

    // the earliest object covering the pixel gives its colour.
    task automatic pixel(input logic [POS_W-1:0] hp, output logic v, output logic [PXL_W-1:0] c);
        logic [POS_W-1:0] dx;
        v = 1'b0;
        c = '0;
        for (int i = 0; i < ref_n && !v; i++) begin
            dx = hp - ref_x[i];
            if (dx < POS_W'(OBJ_SIZE)) begin
                v = 1'b1;
                c = ref_c[i];
            end
        end
    endtask

    task automatic compare_pixel();
        assert (pxl_valid === p_v[2]) else begin
            mism++;
            $display("Mismatch at %0t: pxl_valid expected %b actual %b (vpos %0d hpos %0d)",
                $time, p_v[2], pxl_valid, p_vp[2], p_hp[2]);
        end
        assert (pxl === p_c[2]) else begin
            mism++;
            $display("Mismatch at %0t: pxl expected %h actual %h (vpos %0d hpos %0d)",
                $time, p_c[2], pxl, p_vp[2], p_hp[2]);
        end
        for (int r = 0; r < n_rows; r++) begin
            if (p_act[2] && rows[r].frame == p_fr[2] && rows[r].vpos == p_vp[2] &&
                rows[r].hpos == p_hp[2]) begin
                row_seen[r] = 1'b1;
                assert (pxl_valid === rows[r].v && pxl === rows[r].p) else begin
                    mism++;
                    $display("Mismatch at %0t: pxl row %0d expected %b/%h actual %b/%h",
                        $time, r, rows[r].v, rows[r].p, pxl_valid, pxl);
                end
            end
        end
    endtask

    // follows the VRAM burst: start offset, contiguous steps and its length.
    task automatic watch_burst();
        if (vram_cs && !cs_was) begin
            steps = 0;                           // a new burst begins here.
            assert (vram_addr[TABLE_AW:1] == '0) else begin
                mism++;
                $display("Mismatch at %0t: vram_addr offset expected 0 actual %h",
                    $time, vram_addr[TABLE_AW:1]);
            end
        end
        if (cs_was && vram_addr != va_was) begin
            steps++;
            assert (vram_addr == va_was + 1'b1) else begin
                other++;
                $display("VRAM address jumped from %h to %h at %0t", va_was, vram_addr, $time);
            end
        end
        if (cs_was && !vram_cs) begin
            bursts++;
            assert (steps == FETCH_WORDS) else begin
                mism++;
                $display("Mismatch at %0t: burst words expected %0d actual %0d",
                    $time, FETCH_WORDS, steps);
            end
        end
        cs_was = vram_cs;
        va_was = vram_addr;
    endtask

    // one clock: drive on the rising edge, check the output at the falling edge.
    task automatic tick(input logic v, input logic h, input logic [POS_W-1:0] vp,
                        input logic [POS_W-1:0] hp);
        logic ev;
        logic [PXL_W-1:0] ec;
        @(posedge clk);
        vb   <= v;
        hb   <= h;
        vpos <= vp;
        hpos <= hp;
        pixel(hp, ev, ec);
        for (int i = 2; i > 0; i--) begin
            p_chk[i] = p_chk[i-1];
            p_v[i]   = p_v[i-1];
            p_c[i]   = p_c[i-1];
            p_act[i] = p_act[i-1];
            p_fr[i]  = p_fr[i-1];
            p_vp[i]  = p_vp[i-1];
            p_hp[i]  = p_hp[i-1];
        end
        p_chk[0] = 1'b1;
        p_act[0] = !v && !h;                     // blanking hides every object.
        p_v[0]   = ev && !v && !h;
        p_c[0]   = (ev && !v && !h) ? ec : '0;
        p_fr[0]  = cur_frame;
        p_vp[0]  = vp;
        p_hp[0]  = hp;
        @(negedge clk);
        if (p_chk[2]) compare_pixel();
        watch_burst();
        if (vram_cs) begin
            assert (vram_addr[VRAM_AW:TABLE_AW+1] == vram_base[WORD_W-1:3]) else begin
                other++;
                $display("VRAM address %h at %0t is outside the table window", vram_addr, $time);
            end
        end
    endtask

    initial begin
        logic             v;
        logic [PXL_W-1:0] c;
        logic [POS_W-1:0] line;
        rst = 1'b1;
        vb = 1'b1;
        hb = 1'b0;
        vpos = '0;
        hpos = '0;
        vram_base = 16'h1238;
        img_sel = 1'b0;
        for (int id = 1; id <= 2; id++) begin
            for (int i = 0; i < 2**TABLE_AW; i++) begin
                img[id][i] = WORD_W'(i * 16'h9e37) ^ WORD_W'(id * 16'h1357); // address fill.
            end
        end
        set_obj(1, 0, 100, 40, 16'h0015, 16'h0003); // overlaps entry 1 at x 108..115.
        set_obj(1, 1, 108, 40, 16'h002a, 16'h0007);
        set_obj(1, 2, 505, 500, 16'h0003, 16'h001f); // wraps on both axes.
        for (int k = 3; k <= 8; k++) begin
            set_obj(1, k, 20 + 40 * (k - 3), 195, WORD_W'(k), WORD_W'(k + 8)); // six on line 200.
        end
        set_obj(1, 9, 0, 0, 16'h0000, OBJ_END_ATTR);
        set_obj(1, 10, 300, 40, 16'h0009, 16'h0001); // hidden behind the marker.
        set_obj(2, 0, 200, 60, 16'h0001, 16'h0011);
        set_obj(2, 1, 0, 40, 16'h0002, 16'h0002);
        set_obj(2, 2, 0, 0, 16'h0000, OBJ_END_ATTR);
        set_obj(2, 3, 100, 40, 16'h0004, 16'h0004);
        for (int id = 1; id <= 2; id++) begin
            for (int i = 0; i < 2**TABLE_AW; i++) vram.load_word(id - 1, i, img[id][i]);
        end
        add_row(1, 0, 40, 100, 1'b0, 9'h000);
        add_row(2, 1, 40, 99, 1'b0, 9'h000);
        add_row(2, 1, 40, 100, 1'b1, 9'h035);
        add_row(2, 1, 40, 107, 1'b1, 9'h035);
        add_row(2, 1, 40, 108, 1'b1, 9'h035);
        add_row(2, 1, 40, 115, 1'b1, 9'h035);
        add_row(2, 1, 40, 116, 1'b1, 9'h07a);
        add_row(2, 1, 40, 123, 1'b1, 9'h07a);
        add_row(2, 1, 40, 124, 1'b0, 9'h000);
        add_row(2, 1, 40, 300, 1'b0, 9'h000);
        add_row(2, 1, 39, 100, 1'b0, 9'h000);
        add_row(2, 1, 55, 100, 1'b1, 9'h035);
        add_row(2, 1, 56, 100, 1'b0, 9'h000);
        add_row(2, 1, 200, 20, 1'b1, 9'h0b3);
        add_row(2, 1, 200, 140, 1'b1, 9'h0e6);
        add_row(2, 1, 200, 180, 1'b0, 9'h000);
        add_row(2, 1, 200, 220, 1'b0, 9'h000);
        add_row(2, 1, 3, 505, 1'b1, 9'h1f3);
        add_row(2, 1, 3, 8, 1'b1, 9'h1f3);
        add_row(2, 1, 3, 9, 1'b0, 9'h000);
        add_row(2, 1, 4, 505, 1'b0, 9'h000);
        add_row(3, 2, 40, 0, 1'b1, 9'h022);
        add_row(3, 2, 40, 15, 1'b1, 9'h022);
        add_row(3, 2, 40, 16, 1'b0, 9'h000);
        add_row(3, 2, 40, 100, 1'b0, 9'h000);
        add_row(3, 2, 3, 505, 1'b0, 9'h000);
        for (int r = 0; r < n_rows; r++) begin
            build_lanes(rows[r].img, rows[r].vpos);
            pixel(rows[r].hpos, v, c);
            assert (v === rows[r].v && c === rows[r].p) else begin
                other++;
                $display("row %0d of the stimulus table disagrees with the object rules", r);
            end
        end
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        for (int f = 1; f <= FRAMES; f++) begin
            img_sel   <= (f == 2);               // A is fetched in frame 1, B in frame 2.
            disp_id   = f - 1;                   // shows what the previous frame fetched.
            ref_n     = 0;
            repeat (VB_LEN) tick(1'b1, 1'b0, '0, '0);
            cur_frame = f;
            for (int k = 0; k < LINES; k++) begin
                line = line_at(k);
                if (f == 1 && line < POS_W'(OBJ_SIZE)) continue; // zeroed table covers these.
                build_lanes(disp_id, line);
                repeat (HB_LEN) tick(1'b0, 1'b1, line, '0);
                for (int h = 0; h < 512; h++) tick(1'b0, 1'b0, line, POS_W'(h));
            end
        end
        cur_frame = 0;
        repeat (VB_LEN) tick(1'b1, 1'b0, '0, '0);
        for (int r = 0; r < n_rows; r++) begin
            assert (row_seen[r]) else begin
                other++;
                $display("row %0d of the stimulus table was never reached", r);
            end
        end
        assert (bursts == FRAMES) else begin
            mism++;
            $display("Mismatch at %0t: VRAM bursts expected %0d actual %0d",
                $time, FRAMES, bursts);
        end
        $display("checks done: %0d mismatches, %0d other errors", mism, other);
        if (mism == 0 && other == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- filelist.f
hw/obj_pkg.sv
hw/obj_table.sv
hw/obj_scan.sv
hw/obj_lane.sv
hw/obj_merge.sv
hw/obj_top.sv
sim/obj_vram_model.sv
sim/obj_tb.sv
